// ==== bench/tb_conv_top.sv ====
module tb_conv_top;

    localparam int MAP_WIDTH   = 4;
    localparam int CLK_PERIOD  = 10;
    localparam int TEST_COUNT  = 6;
    localparam int TEST_CYCLES = 200;
    localparam int WAIT_LIMIT  = 40;

    logic           clk;
    logic           reset;
    logic           en;
    mem_pkg::addr_t feature_base;
    logic           wr_en;
    mem_pkg::addr_t wr_addr;
    mem_pkg::data_t wr_data;
    logic           done;
    conv_pkg::acc_t result;
    logic           result_valid;

    // Host side copy of the memory contents
    mem_pkg::data_t mirror [mem_pkg::MEM_DEPTH];
    logic [31:0]    rng_state;
    int             errors;
    int             cyc;
    int             done_cyc [$];
    int             got_cyc [$];
    conv_pkg::acc_t got_val [$];

    conv_top #(
        .MAP_WIDTH (MAP_WIDTH)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .feature_base (feature_base),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .done         (done),
        .result       (result),
        .result_valid (result_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TEST_COUNT * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not finish",
                 TEST_COUNT * TEST_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mem_pkg::data_t random_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[15:8];
    endfunction

    // Signed 3x3 dot product over the mirror
    function automatic int expected_sum(input int base);
        int sum;
        int addr;
        sum = 0;
        for (int r = 0; r < conv_pkg::KERNEL_SIDE; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL_SIDE; c++) begin
                addr = (base + r * MAP_WIDTH + c) % mem_pkg::MEM_DEPTH;
                sum += int'($signed(mirror[3 * r + c])) * int'($signed(mirror[addr]));
            end
        end
        return sum;
    endfunction

    // Outputs are sampled here before any input changes
    task automatic next_cycle();
        @(negedge clk);
        cyc++;
        if (done) begin
            done_cyc.push_back(cyc);
        end
        if (result_valid) begin
            got_cyc.push_back(cyc);
            got_val.push_back(result);
        end
    endtask

    task automatic clear_log();
        done_cyc.delete();
        got_cyc.delete();
        got_val.delete();
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    task automatic write_byte(input mem_pkg::addr_t addr, input mem_pkg::data_t data);
        wr_en        = 1'b1;
        wr_addr      = addr;
        wr_data      = data;
        mirror[addr] = data;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic wait_done(input int n);
        int waited;
        waited = 0;
        while (done_cyc.size() < n && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        check_true(done_cyc.size() >= n, "done did not appear within the wait limit");
    endtask

    task automatic wait_results(input int n);
        int waited;
        waited = 0;
        while (got_val.size() < n && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        check_true(got_val.size() >= n, "result_valid did not appear within the wait limit");
    endtask

    // One window, en dropped in the cycle after done
    task automatic run_window(input mem_pkg::addr_t base);
        int start;
        clear_log();
        start        = cyc;
        feature_base = base;
        en           = 1'b1;
        wait_done(1);
        next_cycle();
        en = 1'b0;
        wait_results(1);
        repeat (3) next_cycle();
        check_int("result_valid pulses", got_val.size(), 1);
        if (done_cyc.size() == 1 && got_val.size() >= 1) begin
            // Enabled cycles up to and including the done cycle
            check_int("done latency", done_cyc[0] - start + 1, conv_pkg::LOAD_STEPS);
            check_int("result_valid delay", got_cyc[0] - done_cyc[0], 4);
            check_int("result", int'(got_val[0]), expected_sum(int'(base)));
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic reset_idle_test();
        clear_log();
        repeat (20) begin
            next_cycle();
            check_int("result", int'(result), 0);
        end
        check_true(done_cyc.size() == 0, "done pulsed while en was low");
        check_true(got_val.size() == 0, "result_valid pulsed while en was low");
    endtask

    // Map bytes hold their offset from the window base
    task automatic unit_weight_test();
        for (int k = 0; k < conv_pkg::KERNEL_TAPS; k++) begin
            write_byte(mem_pkg::addr_t'(k), 8'h01);
        end
        for (int a = 0; a < 16; a++) begin
            write_byte(mem_pkg::addr_t'(16 + a), mem_pkg::data_t'(a));
        end
        run_window(mem_pkg::addr_t'(16));
        if (got_val.size() >= 1) begin
            check_int("result", int'(got_val[0]), 45);
        end
    endtask

    task automatic random_map_test();
        for (int a = 0; a < mem_pkg::MEM_DEPTH; a++) begin
            write_byte(mem_pkg::addr_t'(a), random_byte());
        end
        run_window(mem_pkg::addr_t'(9));
        run_window(mem_pkg::addr_t'(20));
        run_window(mem_pkg::addr_t'(37));
    endtask

    task automatic back_to_back_test();
        clear_log();
        feature_base = mem_pkg::addr_t'(9);
        en           = 1'b1;
        wait_done(1);
        next_cycle();
        // Count 0 of the second window reads a weight, so the base is free to move
        feature_base = mem_pkg::addr_t'(37);
        wait_done(2);
        next_cycle();
        en = 1'b0;
        wait_results(2);
        repeat (3) next_cycle();
        check_int("result_valid pulses", got_val.size(), 2);
        if (done_cyc.size() >= 2 && got_val.size() >= 2) begin
            check_int("window spacing", done_cyc[1] - done_cyc[0], conv_pkg::LOAD_STEPS);
            check_int("first result", int'(got_val[0]), expected_sum(9));
            check_int("second result", int'(got_val[1]), expected_sum(37));
        end
    endtask

    task automatic reset_abort_test();
        clear_log();
        feature_base = mem_pkg::addr_t'(20);
        en           = 1'b1;
        repeat (9) next_cycle();
        reset = 1'b1;
        en    = 1'b0;
        repeat (2) next_cycle();
        reset = 1'b0;
        repeat (10) next_cycle();
        check_true(got_val.size() == 0, "result_valid pulsed for an aborted window");
        check_int("result", int'(result), 0);
        run_window(mem_pkg::addr_t'(20));
    endtask

    task automatic rewrite_test();
        int addr;
        for (int k = 0; k < conv_pkg::KERNEL_TAPS; k++) begin
            write_byte(mem_pkg::addr_t'(k), 8'hfd);
        end
        for (int r = 0; r < conv_pkg::KERNEL_SIDE; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL_SIDE; c++) begin
                addr = 20 + r * MAP_WIDTH + c;
                write_byte(mem_pkg::addr_t'(addr), mem_pkg::data_t'(addr));
            end
        end
        run_window(mem_pkg::addr_t'(20));
        if (got_val.size() >= 1) begin
            check_int("result", int'(got_val[0]), -675);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        en           = 1'b0;
        feature_base = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        errors       = 0;
        cyc          = 0;
        rng_state    = 32'd32;
        repeat (2) next_cycle();
        reset = 1'b0;

        reset_idle_test();
        unit_weight_test();
        random_map_test();
        back_to_back_test();
        reset_abort_test();
        rewrite_test();

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== common/conv_pkg.sv ====
package conv_pkg;

    ////////////////////////////////////////
    // Kernel geometry
    ////////////////////////////////////////

    // Square 3x3 window
    localparam int KERNEL_SIDE = 3;

    localparam int KERNEL_TAPS = KERNEL_SIDE * KERNEL_SIDE;

    // One weight read and one feature read per tap
    localparam int LOAD_STEPS = 2 * KERNEL_TAPS;

    ////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////

    // Load step counter value
    typedef logic [7:0] step_t;

    // Weight or feature byte, two's complement
    typedef logic signed [7:0] pixel_t;

    // Nine products of at most 2^14 each stay inside 20 bits
    typedef logic signed [19:0] acc_t;

endpackage

// ==== common/mem_pkg.sv ====
package mem_pkg;

    // Kernel weights at the bottom, feature map above them
    localparam int MEM_DEPTH = 64;

    typedef logic [$clog2(MEM_DEPTH)-1:0] addr_t;

    typedef logic [7:0] data_t;

    // Weight k sits at WEIGHT_BASE + k
    localparam addr_t WEIGHT_BASE = '0;

endpackage

// ==== common/pe_if.sv ====
// Loader to processing element
interface pe_if;

    conv_pkg::pixel_t weight;
    conv_pkg::pixel_t feature;
    logic             acc_en;
    logic             clear;

    modport source (
        output weight,
        output feature,
        output acc_en,
        output clear
    );

    modport sink (
        input weight,
        input feature,
        input acc_en,
        input clear
    );

endinterface

// ==== hw/conv_top.sv ====
module conv_top #(
    parameter int MAP_WIDTH = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           en,
    input  mem_pkg::addr_t feature_base,
    input  logic           wr_en,
    input  mem_pkg::addr_t wr_addr,
    input  mem_pkg::data_t wr_data,
    output logic           done,
    output conv_pkg::acc_t result,
    output logic           result_valid
);

    mem_pkg::addr_t rd_addr;
    mem_pkg::data_t rd_data;

    pe_if pe_bus ();

    ////////////////////////////////////////
    // Weight and feature memory
    ////////////////////////////////////////

    feature_ram i_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ////////////////////////////////////////
    // Loader and processing element
    ////////////////////////////////////////

    serial_data_loader #(
        .MAP_WIDTH (MAP_WIDTH)
    ) i_loader (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .feature_base (feature_base),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .done         (done),
        .pe           (pe_bus.source)
    );

    mac_pe i_pe (
        .clk          (clk),
        .pe           (pe_bus.sink),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== hw/feature_ram.sv ====
module feature_ram (
    input  logic           clk,
    input  logic           wr_en,
    input  mem_pkg::addr_t wr_addr,
    input  mem_pkg::data_t wr_data,
    input  mem_pkg::addr_t rd_addr,
    output mem_pkg::data_t rd_data
);

    mem_pkg::data_t mem [mem_pkg::MEM_DEPTH];

    ////////////////////////////////////////
    // Host write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Loader read port
    ////////////////////////////////////////

    // Registered read returns the old word when the same address is written
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== hw/loader/serial_data_loader.sv ====
module serial_data_loader #(
    parameter int MAP_WIDTH = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           en,
    input  mem_pkg::addr_t feature_base,
    output mem_pkg::addr_t rd_addr,
    input  mem_pkg::data_t rd_data,
    output logic           done,
    pe_if.source           pe
);

    // Clear lands one idle cycle after the last accumulate
    localparam int CLEAR_DELAY = 3;

    conv_pkg::step_t        count;
    conv_pkg::step_t        tap;
    conv_pkg::step_t        tap_row;
    conv_pkg::step_t        tap_col;
    mem_pkg::addr_t         weight_addr;
    mem_pkg::addr_t         feature_addr;
    logic                   rd_valid_q;
    logic                   rd_odd_q;
    conv_pkg::pixel_t       weight_q;
    logic [CLEAR_DELAY-1:0] done_pipe;

    window_counter i_counter (
        .clk   (clk),
        .reset (reset),
        .en    (en),
        .count (count),
        .done  (done)
    );

    ////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////

    // Even and odd steps of a pair share the same tap
    assign tap     = count >> 1;
    assign tap_row = tap / conv_pkg::step_t'(conv_pkg::KERNEL_SIDE);
    assign tap_col = tap % conv_pkg::step_t'(conv_pkg::KERNEL_SIDE);

    assign weight_addr = mem_pkg::addr_t'(mem_pkg::WEIGHT_BASE + tap);

    // Window base plus row stride plus column
    assign feature_addr = mem_pkg::addr_t'(int'(feature_base)
                                           + int'(tap_row) * MAP_WIDTH
                                           + int'(tap_col));

    assign rd_addr = count[0] ? feature_addr : weight_addr;

    ////////////////////////////////////////
    // Read steering
    ////////////////////////////////////////

    // Parity follows the one cycle memory latency
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
            rd_odd_q   <= 1'b0;
            done_pipe  <= '0;
        end else begin
            rd_valid_q <= en;
            rd_odd_q   <= count[0];
            done_pipe  <= {done_pipe[CLEAR_DELAY-2:0], done};
        end
    end

    // Weight for tap k is held while feature k comes back
    always_ff @(posedge clk) begin
        if (rd_valid_q && !rd_odd_q) begin
            weight_q <= conv_pkg::pixel_t'(rd_data);
        end
    end

    assign pe.weight  = weight_q;
    assign pe.feature = conv_pkg::pixel_t'(rd_data);
    assign pe.acc_en  = rd_valid_q && rd_odd_q;

    // Element also clears for as long as reset lasts
    assign pe.clear   = reset || done_pipe[CLEAR_DELAY-1];

endmodule

// ==== hw/loader/window_counter.sv ====
module window_counter (
    input  logic            clk,
    input  logic            reset,
    input  logic            en,
    output conv_pkg::step_t count,
    output logic            done
);

    logic last_step;

    assign last_step = (count == conv_pkg::step_t'(conv_pkg::LOAD_STEPS - 1));

    // Wraps on its own after the last load step
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (en) begin
            if (last_step) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Flag only while stepping
    assign done = en && last_step;

endmodule

// ==== hw/mac_pe.sv ====
module mac_pe (
    input  logic           clk,
    pe_if.sink             pe,
    output conv_pkg::acc_t result,
    output logic           result_valid
);

    logic signed [2*$bits(conv_pkg::pixel_t)-1:0] product;
    conv_pkg::acc_t                               acc;
    logic                                         clear_q;
    logic                                         valid_q;

    // Full width signed product
    assign product = pe.weight * pe.feature;

    ////////////////////////////////////////
    // Accumulate and capture
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        clear_q <= pe.clear;
        valid_q <= pe.clear && !clear_q;
        if (pe.clear) begin
            // A clear held longer than one cycle comes from reset
            if (clear_q) begin
                result <= '0;
            end else begin
                result <= acc;
            end
            // Next window may start on the same edge
            if (pe.acc_en && !clear_q) begin
                acc <= conv_pkg::acc_t'(product);
            end else begin
                acc <= '0;
            end
        end else if (pe.acc_en) begin
            acc <= acc + conv_pkg::acc_t'(product);
        end
    end

    // Suppressed while reset keeps clear high
    assign result_valid = valid_q && !pe.clear;

endmodule

// ==== list.f ====
common/conv_pkg.sv
common/mem_pkg.sv
common/pe_if.sv
hw/loader/window_counter.sv
hw/loader/serial_data_loader.sv
hw/feature_ram.sv
hw/mac_pe.sv
hw/conv_top.sv
bench/tb_conv_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the convolution engine testbench with Verilator

LOG=sim.log
BUILD=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_conv_top \
    --Mdir "$BUILD" -o tb_conv_top \
    && "./$BUILD/tb_conv_top" > "$LOG" 2>&1 \
    || echo "SIMULATION FAILED" >> "$LOG"

cat "$LOG"

grep -q "SIMULATION FAILED" "$LOG" && exit 1 || exit 0
